// File: source/sfifoPkg.sv
// Shared sizing constants and vector types for the multi-queue FIFO, referenced by scoped name
`default_nettype none

package sfifoPkg;

  // Number of logical FIFOs sharing the storage
  localparam int NumFifos = 4;
  // Total shared entries across all FIFOs
  localparam int Depth = 16;
  // Data word width
  localparam int Width = 8;

  // Derived widths
  localparam int AddrWidth = $clog2(Depth);
  localparam int FifoIdWidth = $clog2(NumFifos);
  // Counts must reach Depth itself
  localparam int CountWidth = $clog2(Depth + 1);

  // One data word
  typedef logic [Width-1:0] dataT;
  // Entry address in the shared RAMs
  typedef logic [AddrWidth-1:0] addrT;
  // Logical FIFO index
  typedef logic [FifoIdWidth-1:0] fifoIdT;
  // Occupancy or credit count
  typedef logic [CountWidth-1:0] countT;
  // One flag per logical FIFO
  typedef logic [NumFifos-1:0] fifoVecT;

endpackage

`default_nettype wire

// File: source/sfifoRam.sv
// Single write, single read register-array RAM with one-cycle read, used for data and pointers
`timescale 1ns/10ps
`default_nettype none

module sfifoRam #(
  parameter int DataWidth = 8
) (
  input  logic                 clk,
  input  logic                 wrValid,
  input  sfifoPkg::addrT       wrAddr,
  input  logic [DataWidth-1:0] wrData,
  input  logic                 rdValid,
  input  sfifoPkg::addrT       rdAddr,
  output logic                 rdDataValid,
  output logic [DataWidth-1:0] rdData
);

  logic [DataWidth-1:0] mem [sfifoPkg::Depth];

  // Write and registered read share the edge, so a same-cycle read sees old data
  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
    rdDataValid <= rdValid;
    if (rdValid) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

`default_nettype wire

// File: source/sfifoPushCtrl.sv
// Push-side controller: credit return, free-address queue and data RAM write for each push
`timescale 1ns/10ps
`default_nettype none

module sfifoPushCtrl (
  input  logic              clk,
  input  logic              rstN,
  input  logic              pushSenderInReset,
  output logic              pushReceiverInReset,
  input  logic              pushCreditStall,
  output logic              pushCredit,
  input  logic              pushValid,
  input  sfifoPkg::dataT    pushData,
  input  sfifoPkg::fifoIdT  pushFifoId,
  output logic              pushFull,
  output logic              dataRamWrValid,
  output sfifoPkg::addrT    dataRamWrAddr,
  output sfifoPkg::dataT    dataRamWrData,
  output logic              nextTailValid,
  output sfifoPkg::fifoIdT  nextTailFifo,
  output sfifoPkg::addrT    nextTail,
  input  logic              deallocValid,
  input  sfifoPkg::addrT    deallocAddr
);

  // Sender reset clears everything below the credit interface
  logic localRstN;

  // Free-address circular queue
  sfifoPkg::addrT  freeList [sfifoPkg::Depth];
  sfifoPkg::addrT  freeRdPtrQ;
  sfifoPkg::addrT  freeWrPtrQ;
  sfifoPkg::countT freeCountQ;

  // Credits owed to the sender
  sfifoPkg::countT pendCreditQ;
  logic            creditIssue;

  assign localRstN = rstN && !pushSenderInReset;

  // Push lands in the data RAM in its own cycle
  assign dataRamWrValid = pushValid;
  assign dataRamWrAddr  = freeList[freeRdPtrQ];
  assign dataRamWrData  = pushData;

  // Same entry handed to the pointer manager for linking
  assign nextTailValid = pushValid;
  assign nextTailFifo  = pushFifoId;
  assign nextTail      = freeList[freeRdPtrQ];

  assign pushFull = freeCountQ == '0;

  // One credit per cycle while owed and not stalled
  assign creditIssue = (pendCreditQ != '0) && !pushCreditStall;

  // Receiver reset indication follows the local reset input only
  always_ff @(posedge clk) begin
    pushReceiverInReset <= !rstN;
  end

  always_ff @(posedge clk) begin
    if (!localRstN) begin
      pushCredit  <= 1'b0;
      pendCreditQ <= sfifoPkg::countT'(sfifoPkg::Depth);
      freeRdPtrQ  <= '0;
      freeWrPtrQ  <= '0;
      freeCountQ  <= sfifoPkg::countT'(sfifoPkg::Depth);
      // Every address starts out free
      for (int i = 0; i < sfifoPkg::Depth; i++) begin
        freeList[i] <= sfifoPkg::addrT'(i);
      end
    end else begin
      pushCredit  <= creditIssue;
      pendCreditQ <= pendCreditQ + sfifoPkg::countT'(deallocValid)
                     - sfifoPkg::countT'(creditIssue);
      freeCountQ  <= freeCountQ + sfifoPkg::countT'(deallocValid)
                     - sfifoPkg::countT'(pushValid);
      // Allocation pops the queue head
      if (pushValid) begin
        freeRdPtrQ <= freeRdPtrQ + 1'b1;
      end
      // Freed entries go to the back
      if (deallocValid) begin
        freeList[freeWrPtrQ] <= deallocAddr;
        freeWrPtrQ           <= freeWrPtrQ + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/sfifoPtrMgr.sv
// Per-FIFO linked-list bookkeeping: heads, tails and counts, with links kept in the pointer RAM
`timescale 1ns/10ps
`default_nettype none

module sfifoPtrMgr (
  input  logic                                    clk,
  input  logic                                    rstN,
  input  logic                                    nextTailValid,
  input  sfifoPkg::fifoIdT                        nextTailFifo,
  input  sfifoPkg::addrT                          nextTail,
  output sfifoPkg::fifoVecT                       headValid,
  output sfifoPkg::addrT [sfifoPkg::NumFifos-1:0] head,
  input  sfifoPkg::fifoVecT                       headReady,
  output sfifoPkg::fifoVecT                       ramEmpty,
  output logic                                    ptrRamWrValid,
  output sfifoPkg::addrT                          ptrRamWrAddr,
  output sfifoPkg::addrT                          ptrRamWrData,
  output logic                                    ptrRamRdValid,
  output sfifoPkg::addrT                          ptrRamRdAddr,
  input  logic                                    ptrRamRdDataValid,
  input  sfifoPkg::addrT                          ptrRamRdData
);

  sfifoPkg::addrT  [sfifoPkg::NumFifos-1:0] headQ;
  sfifoPkg::addrT  [sfifoPkg::NumFifos-1:0] tailQ;
  sfifoPkg::countT [sfifoPkg::NumFifos-1:0] countQ;

  // Successor read outstanding per FIFO
  sfifoPkg::fifoVecT rdPendQ;
  sfifoPkg::fifoIdT  rdFifoQ;

  sfifoPkg::fifoVecT appendVec;
  sfifoPkg::fifoVecT takeHead;
  sfifoPkg::fifoIdT  takeFifo;
  logic              rdReturn;

  assign head = headQ;

  always_comb begin
    takeFifo = '0;
    for (int f = 0; f < sfifoPkg::NumFifos; f++) begin
      ramEmpty[f]  = countQ[f] == '0;
      // Head hidden until the successor pointer is back
      headValid[f] = !ramEmpty[f] && !rdPendQ[f];
      appendVec[f] = nextTailValid && (nextTailFifo == sfifoPkg::fifoIdT'(f));
      takeHead[f]  = headValid[f] && headReady[f];
      if (takeHead[f]) begin
        takeFifo = sfifoPkg::fifoIdT'(f);
      end
    end
  end

  // Link old tail to the new entry when the list is not empty
  assign ptrRamWrValid = nextTailValid && !ramEmpty[nextTailFifo];
  assign ptrRamWrAddr  = tailQ[nextTailFifo];
  assign ptrRamWrData  = nextTail;

  // Fetch the successor only if one is already linked
  assign ptrRamRdValid = (|takeHead) && (countQ[takeFifo] > sfifoPkg::countT'(1));
  assign ptrRamRdAddr  = headQ[takeFifo];

  // Stale returns after a reset are ignored
  assign rdReturn = ptrRamRdDataValid && rdPendQ[rdFifoQ];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      countQ  <= '0;
      rdPendQ <= '0;
    end else begin
      for (int f = 0; f < sfifoPkg::NumFifos; f++) begin
        countQ[f] <= countQ[f] + sfifoPkg::countT'(appendVec[f])
                     - sfifoPkg::countT'(takeHead[f]);
      end
      if (ptrRamRdValid) begin
        rdPendQ[takeFifo] <= 1'b1;
      end
      if (rdReturn) begin
        rdPendQ[rdFifoQ] <= 1'b0;
      end
    end
  end

  // Pointer payload, qualified by the counts above
  always_ff @(posedge clk) begin
    if (ptrRamRdValid) begin
      rdFifoQ <= takeFifo;
    end
    if (rdReturn) begin
      headQ[rdFifoQ] <= ptrRamRdData;
    end
    if (nextTailValid) begin
      tailQ[nextTailFifo] <= nextTail;
      // New entry becomes head when the list is or is about to be empty
      if (ramEmpty[nextTailFifo] ||
          (takeHead[nextTailFifo] && countQ[nextTailFifo] == sfifoPkg::countT'(1))) begin
        headQ[nextTailFifo] <= nextTail;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/sfifoPopCtrl.sv
// Pop-side controller: arbiter requests, data RAM reads, staging slots and address release
`timescale 1ns/10ps
`default_nettype none

module sfifoPopCtrl (
  input  logic                                    clk,
  input  logic                                    rstN,
  input  sfifoPkg::fifoVecT                       headValid,
  input  sfifoPkg::addrT [sfifoPkg::NumFifos-1:0] head,
  output sfifoPkg::fifoVecT                       headReady,
  input  sfifoPkg::fifoVecT                       ramEmpty,
  output sfifoPkg::fifoVecT                       popValid,
  output sfifoPkg::dataT [sfifoPkg::NumFifos-1:0] popData,
  input  sfifoPkg::fifoVecT                       popReady,
  output sfifoPkg::fifoVecT                       popEmpty,
  output logic                                    dataRamRdValid,
  output sfifoPkg::addrT                          dataRamRdAddr,
  input  logic                                    dataRamRdDataValid,
  input  sfifoPkg::dataT                          dataRamRdData,
  output logic                                    deallocValid,
  output sfifoPkg::addrT                          deallocAddr,
  output sfifoPkg::fifoVecT                       arbRequest,
  input  sfifoPkg::fifoVecT                       arbGrant,
  output logic                                    arbEnablePriorityUpdate
);

  // Staging slot per FIFO
  sfifoPkg::fifoVecT                       slotValidQ;
  sfifoPkg::dataT [sfifoPkg::NumFifos-1:0] slotDataQ;
  sfifoPkg::addrT [sfifoPkg::NumFifos-1:0] slotAddrQ;

  // Popped addresses waiting for the single dealloc port
  sfifoPkg::fifoVecT                       freePendQ;
  sfifoPkg::addrT [sfifoPkg::NumFifos-1:0] freeAddrQ;
  sfifoPkg::fifoIdT                        freeFifo;
  sfifoPkg::fifoVecT                       freeSel;

  // Data RAM read in flight
  logic              rdPendQ;
  sfifoPkg::fifoIdT  rdFifoQ;
  sfifoPkg::addrT    rdAddrQ;
  sfifoPkg::fifoIdT  grantFifo;
  sfifoPkg::fifoVecT reserved;
  sfifoPkg::fifoVecT popXfer;
  logic              fillSlot;

  assign reserved = rdPendQ ? (sfifoPkg::fifoVecT'(1) << rdFifoQ) : '0;

  // Slot not shown until its previous address has been released
  assign popValid = slotValidQ & ~freePendQ;
  assign popData  = slotDataQ;
  assign popXfer  = popValid & popReady;
  assign popEmpty = ramEmpty & ~slotValidQ & ~reserved;

  // Request when a head is offered and the slot is free or draining
  assign arbRequest = headValid & ~reserved & (~slotValidQ | popXfer);
  assign headReady  = arbGrant & arbRequest;

  always_comb begin
    grantFifo = '0;
    freeFifo  = '0;
    for (int f = 0; f < sfifoPkg::NumFifos; f++) begin
      if (headReady[f]) begin
        grantFifo = sfifoPkg::fifoIdT'(f);
      end
    end
    // Lowest pending FIFO releases first
    for (int f = sfifoPkg::NumFifos - 1; f >= 0; f--) begin
      if (freePendQ[f]) begin
        freeFifo = sfifoPkg::fifoIdT'(f);
      end
    end
  end

  assign dataRamRdValid          = |headReady;
  assign dataRamRdAddr           = head[grantFifo];
  assign arbEnablePriorityUpdate = dataRamRdValid;

  assign deallocValid = |freePendQ;
  assign deallocAddr  = freeAddrQ[freeFifo];
  assign freeSel      = deallocValid ? (sfifoPkg::fifoVecT'(1) << freeFifo) : '0;

  // Only reads issued since reset fill a slot
  assign fillSlot = dataRamRdDataValid && rdPendQ;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      slotValidQ <= '0;
      freePendQ  <= '0;
      rdPendQ    <= 1'b0;
    end else begin
      rdPendQ    <= dataRamRdValid;
      freePendQ  <= (freePendQ & ~freeSel) | popXfer;
      slotValidQ <= slotValidQ & ~popXfer;
      if (fillSlot) begin
        slotValidQ[rdFifoQ] <= 1'b1;
      end
    end
  end

  // Read tracking and slot payload
  always_ff @(posedge clk) begin
    if (dataRamRdValid) begin
      rdFifoQ <= grantFifo;
      rdAddrQ <= dataRamRdAddr;
    end
    if (fillSlot) begin
      slotDataQ[rdFifoQ] <= dataRamRdData;
      slotAddrQ[rdFifoQ] <= rdAddrQ;
    end
    for (int f = 0; f < sfifoPkg::NumFifos; f++) begin
      if (popXfer[f]) begin
        freeAddrQ[f] <= slotAddrQ[f];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/sfifoRrArbiter.sv
// Round-robin arbiter granting one FIFO per cycle, priority advancing only on update enable
`timescale 1ns/10ps
`default_nettype none

module sfifoRrArbiter (
  input  logic              clk,
  input  logic              rstN,
  input  sfifoPkg::fifoVecT request,
  input  logic              enablePriorityUpdate,
  output sfifoPkg::fifoVecT grant
);

  // Last granted FIFO, search starts just after it
  sfifoPkg::fifoIdT lastQ;
  sfifoPkg::fifoIdT grantIdx;
  sfifoPkg::fifoIdT idx;
  logic             found;

  always_comb begin
    grant    = '0;
    grantIdx = lastQ;
    found    = 1'b0;
    idx      = lastQ;
    // Index wraps in the id width, last grantee checked last
    for (int i = 1; i <= sfifoPkg::NumFifos; i++) begin
      idx = lastQ + sfifoPkg::fifoIdT'(i);
      if (!found && request[idx]) begin
        grant[idx] = 1'b1;
        grantIdx   = idx;
        found      = 1'b1;
      end
    end
  end

  // FIFO 0 wins first after reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      lastQ <= sfifoPkg::fifoIdT'(sfifoPkg::NumFifos - 1);
    end else if (enablePriorityUpdate && found) begin
      lastQ <= grantIdx;
    end
  end

endmodule

`default_nettype wire

// File: source/sharedFifoTop.sv
// Top level of the shared-storage FIFO: controllers, arbiter and both RAMs wired together
`timescale 1ns/10ps
`default_nettype none

module sharedFifoTop (
  input  logic                                    clk,
  input  logic                                    rstN,
  input  logic                                    pushSenderInReset,
  output logic                                    pushReceiverInReset,
  input  logic                                    pushCreditStall,
  output logic                                    pushCredit,
  input  logic                                    pushValid,
  input  sfifoPkg::dataT                          pushData,
  input  sfifoPkg::fifoIdT                        pushFifoId,
  output logic                                    pushFull,
  output sfifoPkg::fifoVecT                       popValid,
  input  sfifoPkg::fifoVecT                       popReady,
  output sfifoPkg::dataT [sfifoPkg::NumFifos-1:0] popData,
  output sfifoPkg::fifoVecT                       popEmpty
);

  // Downstream reset includes the sender being in reset
  logic eitherRstN;

  logic                                    nextTailValid;
  sfifoPkg::fifoIdT                        nextTailFifo;
  sfifoPkg::addrT                          nextTail;
  logic                                    deallocValid;
  sfifoPkg::addrT                          deallocAddr;
  sfifoPkg::fifoVecT                       headValid;
  sfifoPkg::fifoVecT                       headReady;
  sfifoPkg::addrT [sfifoPkg::NumFifos-1:0] head;
  sfifoPkg::fifoVecT                       ramEmpty;
  sfifoPkg::fifoVecT                       arbRequest;
  sfifoPkg::fifoVecT                       arbGrant;
  logic                                    arbEnablePriorityUpdate;

  // Data RAM ports
  logic           dataRamWrValid;
  sfifoPkg::addrT dataRamWrAddr;
  sfifoPkg::dataT dataRamWrData;
  logic           dataRamRdValid;
  sfifoPkg::addrT dataRamRdAddr;
  logic           dataRamRdDataValid;
  sfifoPkg::dataT dataRamRdData;

  // Pointer RAM ports
  logic           ptrRamWrValid;
  sfifoPkg::addrT ptrRamWrAddr;
  sfifoPkg::addrT ptrRamWrData;
  logic           ptrRamRdValid;
  sfifoPkg::addrT ptrRamRdAddr;
  logic           ptrRamRdDataValid;
  sfifoPkg::addrT ptrRamRdData;

  assign eitherRstN = rstN && !pushSenderInReset;

  sfifoPushCtrl sfifoPushCtrl_i (
    .clk, .rstN, .pushSenderInReset, .pushReceiverInReset, .pushCreditStall,
    .pushCredit, .pushValid, .pushData, .pushFifoId, .pushFull,
    .dataRamWrValid, .dataRamWrAddr, .dataRamWrData,
    .nextTailValid, .nextTailFifo, .nextTail, .deallocValid, .deallocAddr
  );

  sfifoPtrMgr sfifoPtrMgr_i (
    .clk, .rstN(eitherRstN), .nextTailValid, .nextTailFifo, .nextTail,
    .headValid, .head, .headReady, .ramEmpty,
    .ptrRamWrValid, .ptrRamWrAddr, .ptrRamWrData, .ptrRamRdValid, .ptrRamRdAddr,
    .ptrRamRdDataValid, .ptrRamRdData
  );

  sfifoPopCtrl sfifoPopCtrl_i (
    .clk, .rstN(eitherRstN), .headValid, .head, .headReady, .ramEmpty,
    .popValid, .popData, .popReady, .popEmpty,
    .dataRamRdValid, .dataRamRdAddr, .dataRamRdDataValid, .dataRamRdData,
    .deallocValid, .deallocAddr, .arbRequest, .arbGrant, .arbEnablePriorityUpdate
  );

  sfifoRrArbiter sfifoRrArbiter_i (
    .clk, .rstN(eitherRstN), .request(arbRequest),
    .enablePriorityUpdate(arbEnablePriorityUpdate), .grant(arbGrant)
  );

  sfifoRam #(.DataWidth(sfifoPkg::Width)) dataRam_i (
    .clk, .wrValid(dataRamWrValid), .wrAddr(dataRamWrAddr), .wrData(dataRamWrData),
    .rdValid(dataRamRdValid), .rdAddr(dataRamRdAddr),
    .rdDataValid(dataRamRdDataValid), .rdData(dataRamRdData)
  );

  sfifoRam #(.DataWidth(sfifoPkg::AddrWidth)) ptrRam_i (
    .clk, .wrValid(ptrRamWrValid), .wrAddr(ptrRamWrAddr), .wrData(ptrRamWrData),
    .rdValid(ptrRamRdValid), .rdAddr(ptrRamRdAddr),
    .rdDataValid(ptrRamRdDataValid), .rdData(ptrRamRdData)
  );

endmodule

`default_nettype wire

// File: verif/clkGen.sv
// Free-running testbench clock with a 100 ns period, starts low at time zero
`timescale 1ns/10ps
`default_nettype none

module clkGen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Half of the 100 ns period
  always #50 clk = ~clk;

endmodule

`default_nettype wire

// File: verif/sharedFifo_sva.sv
// Concurrent protocol checks on the push and pop controllers, bound into the shared FIFO top level
`timescale 1ns/10ps
`default_nettype none

module sharedFifo_sva (
  input logic                                    clk,
  input logic                                    rstN,
  input sfifoPkg::fifoVecT                       popValid,
  input sfifoPkg::fifoVecT                       popReady,
  input sfifoPkg::dataT [sfifoPkg::NumFifos-1:0] popData,
  input sfifoPkg::countT                         pendCredit,
  input logic                                    pushCredit,
  input sfifoPkg::countT                         freeCount
);

  // Assertion failures so far
  int failCount = 0;

  // Back-pressure keeps the offered word in place
  for (genvar f = 0; f < sfifoPkg::NumFifos; f++) begin : holdGen
    popHoldA: assert property (@(posedge clk) disable iff (!rstN)
      popValid[f] && !popReady[f] |=> popValid[f] && $stable(popData[f]))
      else begin
        $error("FIFO %0d changed its pop word under back-pressure", f);
        failCount++;
      end
  end

  // Owed credits plus the one on the wire never exceed the free entries
  creditBoundA: assert property (@(posedge clk) disable iff (!rstN)
    int'(pendCredit) + int'(pushCredit) <= int'(freeCount))
    else begin
      $error("Credits plus resident entries exceed the storage depth");
      failCount++;
    end

  freeBoundA: assert property (@(posedge clk) disable iff (!rstN)
    int'(freeCount) <= sfifoPkg::Depth)
    else begin
      $error("Free entry count above the storage depth");
      failCount++;
    end

endmodule

// Pop signals from the top ports, credit state from inside the push controller
bind sharedFifoTop sharedFifo_sva sharedFifoSva_i (
  .clk(clk), .rstN(eitherRstN), .popValid(popValid), .popReady(popReady), .popData(popData),
  .pendCredit(sfifoPushCtrl_i.pendCreditQ), .pushCredit(pushCredit),
  .freeCount(sfifoPushCtrl_i.freeCountQ)
);

`default_nettype wire

// File: verif/sharedFifoTb.sv
// Table-driven testbench for the shared FIFO with per-FIFO reference queues; run as top module
`timescale 1ns/10ps
`default_nettype none

module sharedFifoTb;

  // Check run after a row has been applied
  typedef enum int {ChkNone, ChkStalled, ChkCredits, ChkDrained, ChkServed, ChkFull,
                    ChkSenderRst} chkT;

  // One clock cycle of stimulus
  typedef struct {
    logic              doPush;
    sfifoPkg::fifoIdT  fifoId;
    sfifoPkg::dataT    data;
    logic              stall;
    sfifoPkg::fifoVecT ready;
    logic              senderRst;
    chkT               chk;
  } rowT;

  logic                                    clk;
  logic                                    rstN;
  logic                                    pushSenderInReset;
  logic                                    pushReceiverInReset;
  logic                                    pushCreditStall;
  logic                                    pushCredit;
  logic                                    pushValid;
  sfifoPkg::dataT                          pushData;
  sfifoPkg::fifoIdT                        pushFifoId;
  logic                                    pushFull;
  sfifoPkg::fifoVecT                       popValid;
  sfifoPkg::fifoVecT                       popReady;
  sfifoPkg::dataT [sfifoPkg::NumFifos-1:0] popData;
  sfifoPkg::fifoVecT                       popEmpty;

  rowT                                     stim [$];
  sfifoPkg::dataT                          modelQ [sfifoPkg::NumFifos][$];
  int                                      popsPerFifo [sfifoPkg::NumFifos];
  // Words seen under back-pressure on the last cycle
  sfifoPkg::fifoVecT                       holdVec;
  sfifoPkg::dataT [sfifoPkg::NumFifos-1:0] holdData;
  int                                      errors;
  int                                      checks;
  int                                      heldCredits;
  int                                      creditsRx;
  int                                      popsEpoch;
  int                                      watchdogNs;
  int                                      svaFails;

  clkGen clkGen_i (.clk);

  sharedFifoTop sharedFifoTop_i (
    .clk, .rstN, .pushSenderInReset, .pushReceiverInReset, .pushCreditStall, .pushCredit,
    .pushValid, .pushData, .pushFifoId, .pushFull, .popValid, .popReady, .popData, .popEmpty
  );

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // fifoSel -1 walks the ids in turn, -2 draws them at random
  task automatic addRows(input int n, input int fifoSel, input logic doPush, input logic stall,
                         input sfifoPkg::fifoVecT ready, input logic senderRst, input chkT chk);
    rowT r;
    for (int i = 0; i < n; i++) begin
      r.doPush = doPush;
      if (fifoSel == -1) begin
        r.fifoId = sfifoPkg::fifoIdT'(i);
      end else if (fifoSel == -2) begin
        r.fifoId = sfifoPkg::fifoIdT'($urandom);
      end else begin
        r.fifoId = sfifoPkg::fifoIdT'(fifoSel);
      end
      r.data      = sfifoPkg::dataT'($urandom);
      r.stall     = stall;
      r.ready     = ready;
      r.senderRst = senderRst;
      r.chk       = (i == n - 1) ? chk : ChkNone;
      stim.push_back(r);
    end
  endtask

  task automatic buildTable();
    // Credit return held off by the stall, then released
    addRows(6, 0, 1'b0, 1'b1, '0, 1'b0, ChkStalled);
    addRows(30, 0, 1'b0, 1'b0, '0, 1'b0, ChkCredits);
    // Ordered traffic through FIFO 1
    addRows(8, 1, 1'b1, 1'b0, '1, 1'b0, ChkNone);
    addRows(30, 0, 1'b0, 1'b0, '1, 1'b0, ChkDrained);
    // Interleaved over all FIFOs
    addRows(24, -1, 1'b1, 1'b0, '1, 1'b0, ChkNone);
    addRows(30, 0, 1'b0, 1'b0, '1, 1'b0, ChkServed);
    // Storage filled while nothing pops
    addRows(20, -2, 1'b1, 1'b0, '0, 1'b0, ChkNone);
    addRows(6, 0, 1'b0, 1'b0, '0, 1'b0, ChkFull);
    // Random ready, then partial drain, then full drain
    for (int i = 0; i < 20; i++) begin
      addRows(1, 0, 1'b0, 1'b0, sfifoPkg::fifoVecT'($urandom), 1'b0, ChkNone);
    end
    addRows(36, 0, 1'b0, 1'b0, 4'b0011, 1'b0, ChkDrained);
    addRows(50, 0, 1'b0, 1'b0, '1, 1'b0, ChkDrained);
    // Sender reset with entries resident
    addRows(6, -2, 1'b1, 1'b0, '0, 1'b0, ChkNone);
    addRows(4, 0, 1'b0, 1'b0, '0, 1'b0, ChkNone);
    addRows(2, 0, 1'b0, 1'b0, '0, 1'b1, ChkSenderRst);
    addRows(30, 0, 1'b0, 1'b0, '1, 1'b0, ChkDrained);
  endtask

  task automatic drainedChecks();
    for (int f = 0; f < sfifoPkg::NumFifos; f++) begin
      checkEq($sformatf("FIFO %0d popEmpty", f), popEmpty[f], modelQ[f].size() == 0);
    end
    // Every pop returns one credit on top of the initial depth
    checkEq("credits received", creditsRx, sfifoPkg::Depth + popsEpoch);
  endtask

  task automatic runChecks(input chkT chk);
    case (chk)
      ChkStalled: checkEq("credits while stalled", creditsRx, 0);
      ChkCredits: begin
        checkEq("credits after reset", creditsRx, sfifoPkg::Depth);
        checkEq("pushReceiverInReset after reset", pushReceiverInReset, 1'b0);
      end
      ChkDrained: drainedChecks();
      ChkServed: begin
        drainedChecks();
        for (int f = 0; f < sfifoPkg::NumFifos; f++) begin
          checkEq($sformatf("FIFO %0d served", f), popsPerFifo[f] > 0, 1'b1);
        end
      end
      ChkFull: begin
        checkEq("pushFull with all entries resident", pushFull, 1'b1);
        checkEq("credits held by sender", heldCredits, 0);
        checkEq("credits received while full", creditsRx, sfifoPkg::Depth + popsEpoch);
      end
      ChkSenderRst: begin
        checkEq("popValid in sender reset", popValid, '0);
        checkEq("popEmpty in sender reset", popEmpty, 4'hf);
      end
      default: ;
    endcase
  endtask

  task automatic sampleOutputs(input logic senderRst);
    sfifoPkg::dataT expData;
    if (!senderRst && pushCredit) begin
      creditsRx++;
      heldCredits++;
    end
    for (int f = 0; f < sfifoPkg::NumFifos; f++) begin
      if (!senderRst && holdVec[f]) begin
        checkEq($sformatf("FIFO %0d popValid held", f), popValid[f], 1'b1);
        checkEq($sformatf("FIFO %0d popData held", f), popData[f], holdData[f]);
      end
      if (popValid[f] && popReady[f]) begin
        if (modelQ[f].size() == 0) begin
          $display("Error at %0t ns: FIFO %0d popped a word that was never pushed", $time, f);
          errors++;
        end else begin
          expData = modelQ[f].pop_front();
          checkEq($sformatf("FIFO %0d pop data", f), popData[f], expData);
          popsEpoch++;
          popsPerFifo[f]++;
        end
      end
    end
    holdVec  = popValid & ~popReady;
    holdData = popData;
  endtask

  // Drive at the rising edge, sample at the falling edge
  task automatic applyRow(input rowT r);
    @(posedge clk);
    if (r.senderRst) begin
      // Sender forgets its credits and the receiver drops its entries
      for (int f = 0; f < sfifoPkg::NumFifos; f++) begin
        modelQ[f].delete();
      end
      heldCredits = 0;
      creditsRx   = 0;
      popsEpoch   = 0;
    end
    pushValid <= 1'b0;
    if (r.doPush && !r.senderRst && heldCredits > 0) begin
      pushValid  <= 1'b1;
      pushData   <= r.data;
      pushFifoId <= r.fifoId;
      modelQ[r.fifoId].push_back(r.data);
      heldCredits--;
    end
    pushCreditStall   <= r.stall;
    popReady          <= r.ready;
    pushSenderInReset <= r.senderRst;
    @(negedge clk);
    sampleOutputs(r.senderRst);
    runChecks(r.chk);
  endtask

  initial begin
    rstN              = 1'b0;
    pushSenderInReset = 1'b0;
    pushCreditStall   = 1'b1;
    pushValid         = 1'b0;
    pushData          = '0;
    pushFifoId        = '0;
    popReady          = '0;
    holdVec           = '0;
    holdData          = '0;
    errors            = 0;
    checks            = 0;
    heldCredits       = 0;
    creditsRx         = 0;
    popsEpoch         = 0;
    svaFails          = 0;
    for (int f = 0; f < sfifoPkg::NumFifos; f++) begin
      popsPerFifo[f] = 0;
    end
    void'($urandom(18));
    buildTable();
    watchdogNs = (stim.size() + 200) * 100;
    fork
      begin
        #(watchdogNs);
        $display("Timeout: the run did not finish within %0d ns", watchdogNs);
        $display("STATUS: FAIL");
        $finish;
      end
    join_none
    @(negedge clk);
    checkEq("pushReceiverInReset during reset", pushReceiverInReset, 1'b1);
    // Second reset edge, then release
    @(posedge clk);
    rstN <= 1'b1;
    foreach (stim[i]) begin
      applyRow(stim[i]);
    end
    svaFails = sharedFifoTop_i.sharedFifoSva_i.failCount;
    $display("Rows: %0d, checks: %0d, pops: %0d, errors: %0d, assertion failures: %0d",
             stim.size(), checks, popsEpoch, errors, svaFails);
    if (errors == 0 && svaFails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/sfifoPkg.sv
source/sfifoRam.sv
source/sfifoPushCtrl.sv
source/sfifoPtrMgr.sv
source/sfifoPopCtrl.sv
source/sfifoRrArbiter.sv
source/sharedFifoTop.sv
verif/clkGen.sv
verif/sharedFifo_sva.sv
verif/sharedFifoTb.sv

// File: Bender.yml
package:
  name: shared_fifo

sources:
  - source/sfifoPkg.sv
  - source/sfifoRam.sv
  - source/sfifoPushCtrl.sv
  - source/sfifoPtrMgr.sv
  - source/sfifoPopCtrl.sv
  - source/sfifoRrArbiter.sv
  - source/sharedFifoTop.sv
  - target: test
    files:
      - verif/clkGen.sv
      - verif/sharedFifo_sva.sv
      - verif/sharedFifoTb.sv
